// File: hdl/spdif_pkg.sv
package spdif_pkg;

    localparam int SAMPLE_W       = 24;
    localparam int HALFBIT_CNT_W  = 5;    // up to 31 clocks per half-bit
    localparam int CSTAT_BITS     = 192;
    localparam int BUF_ADDR_W     = 4;
    localparam int BUF_WORD_W     = 25;   // {chan, sample}
    localparam int UNLOCK_SUBBITS = 128;  // two subframes

    // oldest subbit in the msb, each also accepted inverted
    localparam logic [7:0] SYNC_B = 8'b00010111;
    localparam logic [7:0] SYNC_W = 8'b00011011;
    localparam logic [7:0] SYNC_M = 8'b00011101;

    typedef enum logic [1:0] {
        PRE_NONE,
        PRE_B,
        PRE_M,
        PRE_W
    } preamble_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WR,
        ARB_RD,
        ARB_DONE
    } arb_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_MEM,
        RD_ACK
    } rd_state_t;

endpackage

// File: hdl/buf_mem_if.sv
`timescale 1ns/10ps

interface buf_mem_if;
    import spdif_pkg::*;

    logic                  req;
    logic                  we;
    logic [BUF_ADDR_W-1:0] addr;
    logic [BUF_WORD_W-1:0] wdata;
    logic                  ack;
    logic [BUF_WORD_W-1:0] rdata;  // valid while ack is high

    modport requester (
        output req, we, addr, wdata,
        input  ack, rdata
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output ack, rdata
    );

endinterface

// File: hdl/spdif_bmc_decoder.sv
`timescale 1ns/10ps

module spdif_bmc_decoder (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [spdif_pkg::HALFBIT_CNT_W-1:0] clk_per_halfbit_i,
    input  logic                                line_i,
    output logic                                subbit_strobe_o,
    output logic [7:0]                          subbit_hist_o
);
    import spdif_pkg::*;

    logic [1:0] sync_q;
    logic [1:0] filt_q;
    logic       level_q;
    logic       last_level_q;
    logic signed [HALFBIT_CNT_W:0] phase_q;
    logic signed [HALFBIT_CNT_W:0] full_len;
    logic signed [HALFBIT_CNT_W:0] half_len;

    assign full_len = signed'({1'b0, clk_per_halfbit_i});
    assign half_len = signed'({2'b00, clk_per_halfbit_i[HALFBIT_CNT_W-1:1]});

    // two-flop synchronizer, then two samples for the filter
    always_ff @(posedge clk) begin
        sync_q <= {sync_q[0], line_i};
        filt_q <= {filt_q[0], sync_q[1]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            level_q         <= 1'b0;
            last_level_q    <= 1'b0;
            phase_q         <= '0;
            subbit_strobe_o <= 1'b0;
            subbit_hist_o   <= '0;
        end else begin
            subbit_strobe_o <= 1'b0;
            last_level_q    <= level_q;
            // one-sample glitches never reach the level
            if (filt_q == 2'b00) begin
                level_q <= 1'b0;
            end else if (filt_q == 2'b11) begin
                level_q <= 1'b1;
            end

            if (level_q != last_level_q) begin
                phase_q <= '0;  // resync on every edge
            end else if (phase_q == half_len - 1) begin
                // mid half-bit, next strobe one full half-bit later
                phase_q         <= half_len - full_len;
                subbit_hist_o   <= {subbit_hist_o[6:0], level_q};
                subbit_strobe_o <= 1'b1;
            end else begin
                phase_q <= phase_q + 1;
            end
        end
    end

    a_strobe_single: assert property (
        @(posedge clk) disable iff (rst)
        subbit_strobe_o |=> !subbit_strobe_o
    );

endmodule

// File: hdl/spdif_frame_sync.sv
`timescale 1ns/10ps

module spdif_frame_sync (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             subbit_strobe_i,
    input  logic [7:0]                       subbit_hist_i,
    output logic                             sample_valid_o,
    output logic [spdif_pkg::SAMPLE_W-1:0]   sample_o,
    output logic                             chan_o,
    output logic                             locked_o,
    output logic                             parity_err_o,
    output logic [spdif_pkg::CSTAT_BITS-1:0] cstatus_o
);
    import spdif_pkg::*;

    preamble_t                          pre;
    preamble_t                          cur_pre_q;
    logic [5:0]                         sub_cnt_q;
    logic                               cell_bit;
    logic                               cell_done;
    logic                               last_cell;
    logic [SAMPLE_W+3:0]                data_sr_q;  // audio, V, U, C, P
    logic [SAMPLE_W+3:0]                data_nxt;
    logic [$clog2(UNLOCK_SUBBITS)-1:0]  quiet_cnt_q;
    logic [CSTAT_BITS-1:0]              cs_sr_q;

    always_comb begin
        case (subbit_hist_i)
            SYNC_B, ~SYNC_B: pre = PRE_B;
            SYNC_M, ~SYNC_M: pre = PRE_M;
            SYNC_W, ~SYNC_W: pre = PRE_W;
            default:         pre = PRE_NONE;
        endcase
        if (!subbit_strobe_i) begin
            pre = PRE_NONE;
        end
    end

    // a transition inside the cell is a 1
    assign cell_bit  = subbit_hist_i[1] ^ subbit_hist_i[0];
    assign cell_done = subbit_strobe_i && sub_cnt_q[0] && (sub_cnt_q <= 6'(2 * SAMPLE_W + 7));
    assign last_cell = cell_done && (sub_cnt_q == 6'(2 * SAMPLE_W + 7));  // parity cell
    assign data_nxt  = {cell_bit, data_sr_q[SAMPLE_W+3:1]};

    always_ff @(posedge clk) begin
        if (cell_done) begin
            data_sr_q <= data_nxt;
        end
        if (last_cell) begin
            sample_o <= data_nxt[SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sub_cnt_q      <= '1;  // parked past the data cells
            cur_pre_q      <= PRE_NONE;
            chan_o         <= 1'b0;
            locked_o       <= 1'b0;
            quiet_cnt_q    <= '0;
            sample_valid_o <= 1'b0;
            parity_err_o   <= 1'b0;
            cs_sr_q        <= '0;
            cstatus_o      <= '0;
        end else begin
            sample_valid_o <= 1'b0;
            parity_err_o   <= 1'b0;

            if (pre != PRE_NONE) begin
                sub_cnt_q   <= '0;
                cur_pre_q   <= pre;
                chan_o      <= (pre == PRE_W);
                locked_o    <= 1'b1;
                quiet_cnt_q <= '0;
                if (pre == PRE_B) begin
                    cstatus_o <= cs_sr_q;  // block boundary
                end
            end else if (subbit_strobe_i) begin
                if (sub_cnt_q != 6'h3f) begin
                    sub_cnt_q <= sub_cnt_q + 6'd1;
                end
                if (locked_o) begin
                    if (quiet_cnt_q == UNLOCK_SUBBITS - 1) begin
                        locked_o    <= 1'b0;
                        quiet_cnt_q <= '0;
                    end else begin
                        quiet_cnt_q <= quiet_cnt_q + 1'b1;
                    end
                end
            end

            // even parity over slots 4..31
            if (last_cell && locked_o) begin
                sample_valid_o <= ~^data_nxt;
                parity_err_o   <= ^data_nxt;
                if (cur_pre_q != PRE_W) begin
                    cs_sr_q <= {data_nxt[SAMPLE_W+2], cs_sr_q[CSTAT_BITS-1:1]};
                end
            end
        end
    end

endmodule

// File: hdl/sample_writer.sv
`timescale 1ns/10ps

module sample_writer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             sample_valid_i,
    input  logic [spdif_pkg::SAMPLE_W-1:0]   sample_i,
    input  logic                             chan_i,
    input  logic [spdif_pkg::BUF_ADDR_W:0]   rd_ptr_i,
    buf_mem_if.requester                     mem,
    output logic [spdif_pkg::BUF_ADDR_W:0]   wr_ptr_o,
    output logic                             overflow_o
);
    import spdif_pkg::*;

    logic                  req_q;
    logic [BUF_ADDR_W:0]   wr_ptr_q;
    logic [BUF_WORD_W-1:0] word_q;
    logic                  full;
    logic                  busy;

    // same slot, different lap
    assign full = (wr_ptr_q[BUF_ADDR_W] != rd_ptr_i[BUF_ADDR_W]) &&
                  (wr_ptr_q[BUF_ADDR_W-1:0] == rd_ptr_i[BUF_ADDR_W-1:0]);
    assign busy = req_q || mem.ack;

    always_ff @(posedge clk) begin
        if (sample_valid_i && !busy) begin
            word_q <= {chan_i, sample_i};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q      <= 1'b0;
            wr_ptr_q   <= '0;
            overflow_o <= 1'b0;
        end else if (req_q && mem.ack) begin
            req_q    <= 1'b0;
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end else if (sample_valid_i) begin
            if (full || busy) begin
                overflow_o <= 1'b1;  // sticky, sample lost
            end else begin
                req_q <= 1'b1;
            end
        end
    end

    assign mem.req   = req_q;
    assign mem.we    = 1'b1;
    assign mem.addr  = wr_ptr_q[BUF_ADDR_W-1:0];
    assign mem.wdata = word_q;
    assign wr_ptr_o  = wr_ptr_q;

    a_req_held: assert property (
        @(posedge clk) disable iff (rst)
        $fell(mem.req) |-> $past(mem.ack)
    );

endmodule

// File: hdl/host_reader.sv
`timescale 1ns/10ps

module host_reader (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             host_req_i,
    input  logic [spdif_pkg::BUF_ADDR_W:0]   wr_ptr_i,
    buf_mem_if.requester                     mem,
    output logic [spdif_pkg::BUF_ADDR_W:0]   rd_ptr_o,
    output logic                             host_ack_o,
    output logic [spdif_pkg::BUF_WORD_W-1:0] host_data_o
);
    import spdif_pkg::*;

    rd_state_t             state_q;
    logic                  req_q;
    logic [BUF_ADDR_W:0]   rd_ptr_q;
    logic                  empty;

    assign empty = (wr_ptr_i == rd_ptr_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= RD_IDLE;
            req_q      <= 1'b0;
            rd_ptr_q   <= '0;
            host_ack_o <= 1'b0;
        end else begin
            case (state_q)
                RD_IDLE: begin
                    // wait out the previous ack before asking again
                    if (host_req_i && !empty && !mem.ack) begin
                        req_q   <= 1'b1;
                        state_q <= RD_MEM;
                    end
                end
                RD_MEM: begin
                    if (mem.ack) begin
                        host_data_o <= mem.rdata;
                        req_q       <= 1'b0;
                        host_ack_o  <= 1'b1;
                        state_q     <= RD_ACK;
                    end
                end
                RD_ACK: begin
                    if (!host_req_i) begin
                        host_ack_o <= 1'b0;
                        rd_ptr_q   <= rd_ptr_q + 1'b1;  // word consumed
                        state_q    <= RD_IDLE;
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    assign mem.req   = req_q;
    assign mem.we    = 1'b0;
    assign mem.addr  = rd_ptr_q[BUF_ADDR_W-1:0];
    assign mem.wdata = '0;
    assign rd_ptr_o  = rd_ptr_q;

endmodule

// File: hdl/buf_arbiter.sv
`timescale 1ns/10ps

module buf_arbiter (
    input  logic       clk,
    input  logic       rst,
    buf_mem_if.arbiter wr,
    buf_mem_if.arbiter rd
);
    import spdif_pkg::*;

    arb_state_t            state_q;
    logic                  sel_wr_q;  // writer holds the grant
    logic                  ack_q;
    logic [BUF_WORD_W-1:0] ram [2**BUF_ADDR_W];
    logic [BUF_WORD_W-1:0] rdata_q;
    logic                  access;
    logic                  g_req;
    logic                  g_we;
    logic [BUF_ADDR_W-1:0] g_addr;
    logic [BUF_WORD_W-1:0] g_wdata;

    assign g_req   = sel_wr_q ? wr.req   : rd.req;
    assign g_we    = sel_wr_q ? wr.we    : rd.we;
    assign g_addr  = sel_wr_q ? wr.addr  : rd.addr;
    assign g_wdata = sel_wr_q ? wr.wdata : rd.wdata;
    assign access  = (state_q == ARB_WR) || (state_q == ARB_RD);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= ARB_IDLE;
            sel_wr_q <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (wr.req) begin  // writer first
                        sel_wr_q <= 1'b1;
                        state_q  <= ARB_WR;
                    end else if (rd.req) begin
                        sel_wr_q <= 1'b0;
                        state_q  <= ARB_RD;
                    end
                end
                ARB_WR, ARB_RD: begin
                    ack_q   <= 1'b1;
                    state_q <= ARB_DONE;
                end
                ARB_DONE: begin
                    if (ack_q) begin
                        if (!g_req) begin
                            ack_q <= 1'b0;
                        end
                    end else begin
                        state_q <= ARB_IDLE;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // single port, one access per grant
    always_ff @(posedge clk) begin
        if (access) begin
            if (g_we) begin
                ram[g_addr] <= g_wdata;
            end
            rdata_q <= ram[g_addr];
        end
    end

    assign wr.ack   = ack_q && sel_wr_q;
    assign rd.ack   = ack_q && !sel_wr_q;
    assign wr.rdata = rdata_q;
    assign rd.rdata = rdata_q;

    a_wr_ack_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(wr.ack) |-> $past(wr.req)
    );

    a_rd_ack_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(rd.ack) |-> $past(rd.req)
    );

endmodule

// File: hdl/spdif_rx_top.sv
`timescale 1ns/10ps

module spdif_rx_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [spdif_pkg::HALFBIT_CNT_W-1:0] clk_per_halfbit_i,
    input  logic                                line_i,
    input  logic                                host_req_i,
    output logic                                host_ack_o,
    output logic [spdif_pkg::BUF_WORD_W-1:0]    host_data_o,
    output logic                                locked_o,
    output logic                                parity_err_o,
    output logic                                overflow_o,
    output logic [spdif_pkg::CSTAT_BITS-1:0]    cstatus_o
);
    import spdif_pkg::*;

    logic                subbit_strobe;
    logic [7:0]          subbit_hist;
    logic                sample_valid;
    logic [SAMPLE_W-1:0] sample;
    logic                chan;
    logic [BUF_ADDR_W:0] wr_ptr;
    logic [BUF_ADDR_W:0] rd_ptr;

    buf_mem_if wr_bus ();
    buf_mem_if rd_bus ();

    spdif_bmc_decoder u_bmc (
        .clk               (clk),
        .rst               (rst),
        .clk_per_halfbit_i (clk_per_halfbit_i),
        .line_i            (line_i),
        .subbit_strobe_o   (subbit_strobe),
        .subbit_hist_o     (subbit_hist)
    );

    spdif_frame_sync u_sync (
        .clk             (clk),
        .rst             (rst),
        .subbit_strobe_i (subbit_strobe),
        .subbit_hist_i   (subbit_hist),
        .sample_valid_o  (sample_valid),
        .sample_o        (sample),
        .chan_o          (chan),
        .locked_o        (locked_o),
        .parity_err_o    (parity_err_o),
        .cstatus_o       (cstatus_o)
    );

    sample_writer u_writer (
        .clk            (clk),
        .rst            (rst),
        .sample_valid_i (sample_valid),
        .sample_i       (sample),
        .chan_i         (chan),
        .rd_ptr_i       (rd_ptr),
        .mem            (wr_bus.requester),
        .wr_ptr_o       (wr_ptr),
        .overflow_o     (overflow_o)
    );

    host_reader u_reader (
        .clk         (clk),
        .rst         (rst),
        .host_req_i  (host_req_i),
        .wr_ptr_i    (wr_ptr),
        .mem         (rd_bus.requester),
        .rd_ptr_o    (rd_ptr),
        .host_ack_o  (host_ack_o),
        .host_data_o (host_data_o)
    );

    // one ram, writer side wins ties
    buf_arbiter u_arb (
        .clk (clk),
        .rst (rst),
        .wr  (wr_bus.arbiter),
        .rd  (rd_bus.arbiter)
    );

endmodule

// File: verif/spdif_checker.sv
`timescale 1ns/10ps

module spdif_checker (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             host_ack_i,
    input  logic [spdif_pkg::BUF_WORD_W-1:0] host_data_i,
    input  logic                             locked_i,
    input  logic                             parity_err_i,
    input  logic                             overflow_i,
    input  logic [spdif_pkg::CSTAT_BITS-1:0] cstatus_i,
    output int                               pending_o,
    output int                               error_cnt_o
);
    import spdif_pkg::*;

    logic [BUF_WORD_W-1:0] stored [$];  // words the buffer should hold
    logic [BUF_WORD_W-1:0] exp_word;
    logic                  ack_q;
    logic                  ovf_exp = 1'b0;
    int                    errors = 0;
    int                    test_errors = 0;
    int                    tests = 0;
    int                    perr_seen = 0;
    int                    perr_exp = 0;

    assign pending_o   = stored.size();
    assign error_cnt_o = errors;

    task automatic report_value(input string name, input logic [CSTAT_BITS-1:0] got,
                                input logic [CSTAT_BITS-1:0] exp);
        $display("FAIL %s: got %h, expected %h", name, got, exp);
        errors++;
        test_errors++;
    endtask

    // called by the encoder just before the parity cell goes out
    task automatic expect_subframe(input logic [BUF_WORD_W-1:0] word, input logic good);
        if (!good) begin
            perr_exp++;
        end else if (stored.size() < 2**BUF_ADDR_W) begin
            stored.push_back(word);
        end else begin
            ovf_exp = 1'b1;  // buffer full, sample lost
        end
    endtask

    task automatic check_locked(input logic exp);
        if (locked_i !== exp) report_value("locked_o", CSTAT_BITS'(locked_i), CSTAT_BITS'(exp));
    endtask

    task automatic check_cstatus(input logic [CSTAT_BITS-1:0] exp);
        if (cstatus_i !== exp) report_value("cstatus_o", cstatus_i, exp);
    endtask

    task automatic check_overflow();
        if (overflow_i !== ovf_exp) begin
            report_value("overflow_o", CSTAT_BITS'(overflow_i), CSTAT_BITS'(ovf_exp));
        end
    endtask

    task automatic check_parity();
        if (perr_seen != perr_exp) begin
            report_value("parity_err_o pulses", CSTAT_BITS'(perr_seen), CSTAT_BITS'(perr_exp));
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errors == 0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic report();
        $display("summary: %0d tests run, %0d errors", tests, errors);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= host_ack_i;
            if (host_ack_i && !ack_q) begin
                if (stored.size() == 0) begin
                    $display("host_ack_o rose while no sample was expected in the buffer");
                    errors++;
                    test_errors++;
                end else begin
                    exp_word = stored.pop_front();
                    if (host_data_i !== exp_word) begin
                        report_value("host_data_o", CSTAT_BITS'(host_data_i),
                                     CSTAT_BITS'(exp_word));
                    end
                end
            end
            if (parity_err_i) perr_seen++;
        end
    end

endmodule

// File: verif/tb_spdif_rx.sv
`timescale 1ns/10ps

module tb_spdif_rx;
    import spdif_pkg::*;

    localparam int SEED        = 78247;
    localparam int HALFBIT     = 8;
    localparam int SUBFRAMES   = 2 * 192 + 2 * 12 + 16;  // both blocks plus idle time
    localparam int CYCLE_LIMIT = SUBFRAMES * 64 * HALFBIT + 20000;
    localparam int PROBE_NONE  = 0;
    localparam int PROBE_LOCK  = 1;
    localparam int PROBE_CSTAT = 2;

    logic                     clk;
    logic                     rst;
    logic [HALFBIT_CNT_W-1:0] clk_per_halfbit_i;
    logic                     line_i;
    logic                     host_req_i;
    logic                     host_ack_o;
    logic [BUF_WORD_W-1:0]    host_data_o;
    logic                     locked_o;
    logic                     parity_err_o;
    logic                     overflow_o;
    logic [CSTAT_BITS-1:0]    cstatus_o;
    logic [CSTAT_BITS-1:0]    cs_blk;  // left C bits of the current block
    logic                     lvl;     // line level as last driven
    logic                     host_run;
    logic                     host_busy;
    int                       probe;
    int                       pending;
    int                       error_cnt;
    int                       cycles;

    spdif_rx_top u_dut (
        .clk               (clk),
        .rst               (rst),
        .clk_per_halfbit_i (clk_per_halfbit_i),
        .line_i            (line_i),
        .host_req_i        (host_req_i),
        .host_ack_o        (host_ack_o),
        .host_data_o       (host_data_o),
        .locked_o          (locked_o),
        .parity_err_o      (parity_err_o),
        .overflow_o        (overflow_o),
        .cstatus_o         (cstatus_o)
    );

    spdif_checker u_chk (
        .clk          (clk),
        .rst          (rst),
        .host_ack_i   (host_ack_o),
        .host_data_i  (host_data_o),
        .locked_i     (locked_o),
        .parity_err_i (parity_err_o),
        .overflow_i   (overflow_o),
        .cstatus_i    (cstatus_o),
        .pending_o    (pending),
        .error_cnt_o  (error_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic send_half(input logic v);
        @(posedge clk);
        #1 line_i = v;
        lvl = v;
        repeat (HALFBIT - 1) @(posedge clk);
    endtask

    // biphase mark: edge at every cell start, another mid-cell for a 1
    task automatic send_cell(input logic b);
        send_half(~lvl);
        send_half(b ? ~lvl : lvl);
    endtask

    task automatic send_preamble(input logic [7:0] pat);
        logic [7:0] p;
        int         i;
        p = lvl ? pat : ~pat;  // first subbit must flip the line
        for (i = 7; i >= 0; i--) begin
            send_half(p[i]);
        end
    endtask

    task automatic run_probe();
        if (probe == PROBE_LOCK) u_chk.check_locked(1'b1);
        else if (probe == PROBE_CSTAT) u_chk.check_cstatus(cs_blk);
        probe = PROBE_NONE;
    endtask

    task automatic send_subframe(input logic [7:0] pat, input logic [SAMPLE_W-1:0] smp,
                                 input logic c, input logic bad, input logic with_pre);
        logic [27:0]           bits;
        logic [BUF_WORD_W-1:0] word;
        int                    i;
        bits     = {1'b0, c, 2'b00, smp};  // P C U V audio
        bits[27] = (^bits[26:0]) ^ bad;
        word     = {pat == SYNC_W, smp};
        if (with_pre) send_preamble(pat);
        for (i = 0; i < 27; i++) begin
            send_cell(bits[i]);
            if (i == 3) run_probe();
        end
        if (with_pre) u_chk.expect_subframe(word, !bad);
        send_cell(bits[27]);
    endtask

    task automatic send_frame(input logic first, input int idx, input logic allow_bad);
        logic [SAMPLE_W-1:0] smp;
        logic                c;
        logic                bad;
        smp = SAMPLE_W'($urandom);
        c   = 1'($urandom % 2);
        bad = allow_bad && ($urandom % 16 == 0);
        send_subframe(first ? SYNC_B : SYNC_M, smp, c, bad, 1'b1);
        cs_blk[idx] = c;
        smp = SAMPLE_W'($urandom);
        bad = allow_bad && ($urandom % 16 == 0);
        send_subframe(SYNC_W, smp, 1'($urandom % 2), bad, 1'b1);
    endtask

    task automatic wait_drain();
        while (pending != 0 || host_busy) @(posedge clk);
        repeat (20) @(posedge clk);
    endtask

    // four-phase host reads, only while the model expects a word
    initial begin
        host_busy = 1'b0;
        forever begin
            @(posedge clk);
            if (host_run && pending > 0 && !rst) begin
                host_busy = 1'b1;
                #1 host_req_i = 1'b1;
                @(posedge clk);
                while (!host_ack_o) @(posedge clk);
                #1 host_req_i = 1'b0;
                @(posedge clk);
                while (host_ack_o) @(posedge clk);
                host_busy = 1'b0;
                repeat ($urandom % 4) @(posedge clk);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int f;
        void'($urandom(SEED));
        rst               = 1'b1;
        line_i            = 1'b0;
        lvl               = 1'b0;
        host_req_i        = 1'b0;
        host_run          = 1'b0;
        clk_per_halfbit_i = HALFBIT_CNT_W'(HALFBIT);
        probe             = PROBE_NONE;
        cs_blk            = '0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        repeat (20) @(posedge clk);

        u_chk.check_locked(1'b0);
        host_run = 1'b1;
        for (f = 0; f < 192; f++) begin
            if (f == 0) probe = PROBE_LOCK;
            send_frame(f == 0, f, 1'b1);
            if (f == 0) u_chk.end_test("lock");
        end
        wait_drain();
        u_chk.check_overflow();
        u_chk.end_test("samples in order");
        u_chk.check_parity();
        u_chk.end_test("parity drop");

        // host stalled across 24 subframes
        host_run = 1'b0;
        for (f = 0; f < 12; f++) begin
            if (f == 0) probe = PROBE_CSTAT;
            send_frame(f == 0, f, 1'b0);
            if (f == 0) u_chk.end_test("channel status");
        end
        repeat (20) @(posedge clk);
        u_chk.check_overflow();
        host_run = 1'b1;
        wait_drain();
        u_chk.end_test("overflow");

        host_run = 1'b0;
        repeat (200 * HALFBIT) @(posedge clk);
        u_chk.check_locked(1'b0);
        send_subframe(SYNC_M, SAMPLE_W'($urandom), 1'b0, 1'b0, 1'b0);
        @(posedge clk);
        #1 host_req_i = 1'b1;  // any ack here is flagged by the checker
        repeat (300) @(posedge clk);
        #1 host_req_i = 1'b0;
        repeat (10) @(posedge clk);
        u_chk.end_test("loss of lock");

        u_chk.report();
        if (error_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: spdif_rx.f
hdl/spdif_pkg.sv
hdl/buf_mem_if.sv
hdl/spdif_bmc_decoder.sv
hdl/spdif_frame_sync.sv
hdl/sample_writer.sv
hdl/host_reader.sv
hdl/buf_arbiter.sv
hdl/spdif_rx_top.sv
verif/spdif_checker.sv
verif/tb_spdif_rx.sv

// File: run_sim.sh
#!/bin/sh
# build and run the S/PDIF receiver testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_spdif_rx \
    -f spdif_rx.f > build.log 2>&1 &&
./obj_dir/Vtb_spdif_rx > sim.log 2>&1 ||
echo "build or simulation did not complete"
touch sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log and build.log"; exit 1; }
